// ==== rtl/scope_config.svh ====
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

// width of one ADC sample as delivered by the AD9280
`define SCOPE_SAMPLE_W 8

// wave buffer address width, depth is 2**SCOPE_BUF_AW words
`define SCOPE_BUF_AW 10

// width of the programmable decimation factor
`define SCOPE_DECI_W 16

// APB byte address width and the start of the buffer read window
`define SCOPE_APB_AW 13
`define SCOPE_BUF_BASE 13'h1000

`endif

// ==== rtl/scope_regs_pkg.sv ====
`include "scope_config.svh"

package scope_regs_pkg;

  // register byte offsets within the APB space
  localparam logic [`SCOPE_APB_AW-1:0] CTRL_OFFS   = 'h000;
  localparam logic [`SCOPE_APB_AW-1:0] STATUS_OFFS = 'h004;

  // STATUS bit positions
  localparam int STATUS_DONE_BIT  = 0;
  localparam int STATUS_ARMED_BIT = 1;

  // CTRL layout, msb first: deci_factor 31:16, trig_level 15:8, edge 1, run 0
  typedef struct packed {
    logic [`SCOPE_DECI_W-1:0]   deci_factor;
    logic [`SCOPE_SAMPLE_W-1:0] trig_level;
    logic [5:0]                 rsvd;
    logic                       trig_edge;
    logic                       run;
  } ctrl_fields_t;

  // the same CTRL word seen either as the raw bus value or as its fields
  typedef union packed {
    logic [31:0]  raw;
    ctrl_fields_t fields;
  } ctrl_word_u;

endpackage

// ==== rtl/scope_capture_pkg.sv ====
`include "scope_config.svh"

package scope_capture_pkg;

  // one raw or decimated ADC sample
  typedef logic [`SCOPE_SAMPLE_W-1:0] sample_t;

  // word address into the wave buffer
  typedef logic [`SCOPE_BUF_AW-1:0] buf_addr_t;

  // sampler FSM: a single idle cycle after reset, then fill and arm in turn
  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_sample    = 2'd1,
    st_wait_trig = 2'd2
  } sample_state_e;

endpackage

// ==== rtl/ad_decimator.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module ad_decimator (
  input  logic                     ad_clk,
  input  logic                     rst_n,
  input  logic                     run,
  input  logic [`SCOPE_DECI_W-1:0] deci_factor,
  output logic                     deci_valid
);

  // clocks remaining until the next decimated sample
  logic [`SCOPE_DECI_W-1:0] cnt;

  // the counter sits at zero while stopped, so the strobe comes in the
  // first clock after run goes high
  always_ff @(posedge ad_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;
    end else if (cnt == '0) begin
      // reload gives a period of deci_factor+1 clocks
      cnt <= deci_factor;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  assign deci_valid = run && (cnt == '0);

endmodule

// ==== rtl/ad9280_sample.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module ad9280_sample import scope_capture_pkg::*; (
  input  logic      ad_clk,
  input  logic      rst_n,
  input  sample_t   ad_data,
  input  logic      deci_valid,
  input  logic      run,
  input  sample_t   trig_level,
  input  logic      trig_edge,
  output logic      buf_wr,
  output buf_addr_t buf_addr,
  output sample_t   buf_data,
  output logic      frame_done,
  output logic      armed
);

  sample_state_e state;

  // raw ADC word from the previous clock, used for the crossing compare
  sample_t ad_data_d0;

  // set once a fill has been started by a trigger
  logic trig_fill;

  logic trig_hit;
  logic last_wr;

  always_ff @(posedge ad_clk) begin
    ad_data_d0 <= ad_data;
  end

  // level crossing on the raw stream, trig_edge high selects rising
  always_comb begin
    if (trig_edge) begin
      trig_hit = (ad_data_d0 < trig_level) && (ad_data >= trig_level);
    end else begin
      trig_hit = (ad_data_d0 > trig_level) && (ad_data <= trig_level);
    end
  end

  // writes happen in the same clock as the decimated strobe
  assign buf_wr   = (state == st_sample) && run && deci_valid;
  assign buf_data = ad_data;
  assign armed    = (state == st_wait_trig);

  // frame done marks the write to the last address of a triggered fill
  assign last_wr    = buf_wr && (buf_addr == '1);
  assign frame_done = last_wr && trig_fill;

  always_ff @(posedge ad_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      buf_addr  <= '0;
      trig_fill <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // the first fill after reset starts without waiting for a trigger
          state <= st_sample;
        end
        st_sample: begin
          if (buf_wr) begin
            // the address wraps to zero after the last word
            buf_addr <= buf_addr + 1'b1;
            if (last_wr) begin
              state <= st_wait_trig;
            end
          end
        end
        st_wait_trig: begin
          // deci_valid is only high while running, so a stopped scope holds here
          if (deci_valid && trig_hit) begin
            state     <= st_sample;
            buf_addr  <= '0;
            trig_fill <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== rtl/wave_buffer.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module wave_buffer import scope_capture_pkg::*; (
  input  logic      ad_clk,
  input  logic      wr_en,
  input  buf_addr_t wr_addr,
  input  sample_t   wr_data,
  input  logic      rd_en,
  input  buf_addr_t rd_addr,
  output sample_t   rd_data
);

  localparam int DEPTH = 1 << `SCOPE_BUF_AW;

  // one sample per word, written by the sampler and read back over APB
  sample_t mem [0:DEPTH-1];

  // write port
  always_ff @(posedge ad_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, data is valid the clock after rd_en
  always_ff @(posedge ad_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== rtl/scope_apb_regs.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module scope_apb_regs import scope_capture_pkg::*, scope_regs_pkg::*; (
  input  logic                     ad_clk,
  input  logic                     rst_n,
  input  logic [`SCOPE_APB_AW-1:0] paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     run,
  output logic                     trig_edge,
  output sample_t                  trig_level,
  output logic [`SCOPE_DECI_W-1:0] deci_factor,
  input  logic                     frame_done,
  input  logic                     armed,
  output logic                     buf_rd_en,
  output buf_addr_t                buf_rd_addr,
  input  sample_t                  buf_rd_data
);

  ctrl_word_u ctrl_q;
  ctrl_word_u wr_word;

  logic done_q;
  logic rd_pend;

  logic access;
  logic is_ctrl;
  logic is_status;
  logic is_buf;
  logic unmapped;
  logic buf_read;
  logic ctrl_wr;

  logic [`SCOPE_APB_AW-1:0] buf_off;
  logic [31:0]              status_word;

  // address decode
  assign access    = psel && penable;
  assign is_ctrl   = (paddr == CTRL_OFFS);
  assign is_status = (paddr == STATUS_OFFS);
  assign is_buf    = (paddr >= `SCOPE_BUF_BASE);
  assign unmapped  = !is_ctrl && !is_status && !is_buf;
  assign buf_read  = is_buf && !pwrite;

  // byte offset into the window, the word index is the sample index
  assign buf_off     = paddr - `SCOPE_BUF_BASE;
  assign buf_rd_addr = buf_off[`SCOPE_BUF_AW+1:2];

  // the RAM read goes out in the first access cycle and returns in the second
  assign buf_rd_en = access && buf_read && !rd_pend;

  always_ff @(posedge ad_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= buf_rd_en;
    end
  end

  // only buffer reads wait, everything else completes at once
  assign pready  = access && (!buf_read || rd_pend);
  assign pslverr = access && (unmapped || (is_buf && pwrite));

  // incoming bus word decoded as CTRL fields
  assign wr_word.raw = pwdata;
  assign ctrl_wr     = access && pwrite && is_ctrl;

  always_ff @(posedge ad_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q.raw <= '0;
    end else if (ctrl_wr) begin
      ctrl_q.raw <= wr_word.raw;
    end
  end

  // sticky done, cleared when software starts a new run
  always_ff @(posedge ad_clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (frame_done) begin
      done_q <= 1'b1;
    end else if (ctrl_wr && wr_word.fields.run && !ctrl_q.fields.run) begin
      done_q <= 1'b0;
    end
  end

  always_comb begin
    status_word                   = '0;
    status_word[STATUS_DONE_BIT]  = done_q;
    status_word[STATUS_ARMED_BIT] = armed;
  end

  // read data mux, samples are zero-extended to the bus width
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (is_ctrl) begin
        prdata = ctrl_q.raw;
      end else if (is_status) begin
        prdata = status_word;
      end else if (is_buf && rd_pend) begin
        prdata = {{(32-`SCOPE_SAMPLE_W){1'b0}}, buf_rd_data};
      end
    end
  end

  assign run         = ctrl_q.fields.run;
  assign trig_edge   = ctrl_q.fields.trig_edge;
  assign trig_level  = ctrl_q.fields.trig_level;
  assign deci_factor = ctrl_q.fields.deci_factor;

endmodule

// ==== rtl/scope_capture.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module scope_capture import scope_capture_pkg::*; (
  input  logic                     ad_clk,
  input  logic                     rst_n,
  input  sample_t                  ad_data,
  input  logic [`SCOPE_APB_AW-1:0] paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr
);

  // controls from the register block
  logic                     run;
  logic                     trig_edge;
  sample_t                  trig_level;
  logic [`SCOPE_DECI_W-1:0] deci_factor;

  logic deci_valid;

  // sampler to buffer and status
  logic      buf_wr;
  buf_addr_t buf_addr;
  sample_t   buf_data;
  logic      frame_done;
  logic      armed;

  // APB readback path into the buffer
  logic      buf_rd_en;
  buf_addr_t buf_rd_addr;
  sample_t   buf_rd_data;

  ad_decimator u_decimator (
    .ad_clk      (ad_clk),
    .rst_n       (rst_n),
    .run         (run),
    .deci_factor (deci_factor),
    .deci_valid  (deci_valid)
  );

  ad9280_sample u_sample (
    .ad_clk     (ad_clk),
    .rst_n      (rst_n),
    .ad_data    (ad_data),
    .deci_valid (deci_valid),
    .run        (run),
    .trig_level (trig_level),
    .trig_edge  (trig_edge),
    .buf_wr     (buf_wr),
    .buf_addr   (buf_addr),
    .buf_data   (buf_data),
    .frame_done (frame_done),
    .armed      (armed)
  );

  wave_buffer u_buffer (
    .ad_clk  (ad_clk),
    .wr_en   (buf_wr),
    .wr_addr (buf_addr),
    .wr_data (buf_data),
    .rd_en   (buf_rd_en),
    .rd_addr (buf_rd_addr),
    .rd_data (buf_rd_data)
  );

  scope_apb_regs u_regs (
    .ad_clk      (ad_clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .run         (run),
    .trig_edge   (trig_edge),
    .trig_level  (trig_level),
    .deci_factor (deci_factor),
    .frame_done  (frame_done),
    .armed       (armed),
    .buf_rd_en   (buf_rd_en),
    .buf_rd_addr (buf_rd_addr),
    .buf_rd_data (buf_rd_data)
  );

endmodule

// ==== verification/scope_capture_asserts.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module scope_capture_asserts (
  input logic                     ad_clk,
  input logic                     rst_n,
  input logic [`SCOPE_APB_AW-1:0] paddr,
  input logic                     psel,
  input logic                     pwrite,
  input logic [31:0]              pwdata,
  input logic                     pready,
  input logic [`SCOPE_BUF_AW-1:0] buf_addr,
  input logic                     run,
  input logic                     frame_done,
  input logic                     armed
);

  // number of assertion failures so far
  int fail_count = 0;

  // the master holds address and controls until the slave raises pready
  apb_stable_check: assert property (
    @(posedge ad_clk) disable iff (!rst_n)
      (psel && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata))
  ) else begin
    fail_count++;
    $error("APB address or controls changed while the transfer was waiting");
  end

  // a stopped scope neither writes nor advances the buffer address
  stopped_hold_check: assert property (
    @(posedge ad_clk) disable iff (!rst_n) !run |=> $stable(buf_addr)
  ) else begin
    fail_count++;
    $error("buffer address moved while run is low");
  end

  // after the last write of a frame the sampler arms for the next trigger
  done_then_armed_check: assert property (
    @(posedge ad_clk) disable iff (!rst_n) frame_done |=> armed
  ) else begin
    fail_count++;
    $error("sampler did not arm after frame done");
  end

endmodule

bind scope_capture scope_capture_asserts u_asserts (
  .ad_clk     (ad_clk),
  .rst_n      (rst_n),
  .paddr      (paddr),
  .psel       (psel),
  .pwrite     (pwrite),
  .pwdata     (pwdata),
  .pready     (pready),
  .buf_addr   (buf_addr),
  .run        (run),
  .frame_done (frame_done),
  .armed      (armed)
);

// ==== verification/scope_capture_tb.sv ====
`timescale 1ns/100ps
`include "scope_config.svh"

module scope_capture_tb
  import scope_regs_pkg::*;
();

  localparam int CLK_HALF  = 5;
  localparam int SETTLE    = 2;
  localparam int APB_LIMIT = 16;
  localparam int BUF_DEPTH = 1 << `SCOPE_BUF_AW;

  logic                       ad_clk = 1'b0;
  logic                       rst_n;
  logic [`SCOPE_SAMPLE_W-1:0] ad_data = '0;
  logic [`SCOPE_APB_AW-1:0]   paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;

  logic [`SCOPE_SAMPLE_W-1:0] ramp_step = '0;
  logic [`SCOPE_SAMPLE_W-1:0] words [0:BUF_DEPTH-1];
  int                         cycle_cnt = 0;
  int                         check_cnt = 0;
  int                         value_errors = 0;
  int                         other_errors = 0;

  scope_capture dut (
    .ad_clk  (ad_clk),
    .rst_n   (rst_n),
    .ad_data (ad_data),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_HALF) ad_clk = ~ad_clk;

  always @(posedge ad_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // the ADC ramp moves by the current step on every clock
  always @(negedge ad_clk) begin
    if (rst_n) begin
      ad_data <= ad_data + ramp_step;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      value_errors++;
      $display("** Error: %s expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [`SCOPE_APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int   waits;
    int   exp_waits;
    logic done;
    rdata = '0;
    err   = 1'b0;
    done  = 1'b0;
    waits = 0;
    // buffer reads wait one cycle for the registered RAM, all other accesses none
    exp_waits = (!wr && addr >= `SCOPE_BUF_BASE) ? 1 : 0;
    @(negedge ad_clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge ad_clk);
    penable = 1'b1;
    while (!done && waits < APB_LIMIT) begin
      // slave outputs have settled well before the completing rising edge
      #(SETTLE);
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        waits++;
        @(negedge ad_clk);
      end
    end
    if (!done) begin
      other_errors++;
      $display("APB transfer to 0x%h got no pready within %0d cycles", addr, APB_LIMIT);
    end else begin
      check_value("pready_wait_states", exp_waits, waits);
    end
    @(negedge ad_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [`SCOPE_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`SCOPE_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic check_registers();
    ctrl_word_u  ctrl;
    logic [31:0] rdata;
    logic        err;
    ctrl.raw                = '0;
    ctrl.fields.deci_factor = 16'h00a5;
    ctrl.fields.trig_level  = 8'h3c;
    ctrl.fields.trig_edge   = 1'b1;
    apb_write(CTRL_OFFS, ctrl.raw, err);
    check_value("pslverr", 32'd0, err);
    apb_read(CTRL_OFFS, rdata, err);
    check_value("prdata", ctrl.raw, rdata);
    check_value("pslverr", 32'd0, err);
    apb_read(STATUS_OFFS, rdata, err);
    check_value("status_done", 32'd0, rdata[STATUS_DONE_BIT]);
    // holes below the buffer window and writes into it are refused
    apb_read(13'h008, rdata, err);
    check_value("pslverr", 32'd1, err);
    apb_read(13'h0ffc, rdata, err);
    check_value("pslverr", 32'd1, err);
    apb_write(`SCOPE_BUF_BASE + 13'h010, 32'h55, err);
    check_value("pslverr", 32'd1, err);
  endtask

  task automatic run_capture(input int deci, input int level, input int rise,
                             input int step, input int nwords);
    ctrl_word_u                 ctrl;
    logic [31:0]                rdata;
    logic                       err;
    logic                       done;
    int                         start;
    int                         limit;
    int                         prod;
    int                         i;
    logic [`SCOPE_SAMPLE_W-1:0] inc;
    logic [`SCOPE_SAMPLE_W-1:0] exp_word;
    logic [`SCOPE_SAMPLE_W-1:0] trig;
    logic [`SCOPE_SAMPLE_W-1:0] prev;
    $display("capture with deci_factor %0d, level %0d, %s edge, step %0d, %0d words",
             deci, level, (rise != 0) ? "rising" : "falling", step, nwords);
    ctrl.raw                = '0;
    ctrl.fields.deci_factor = deci[`SCOPE_DECI_W-1:0];
    ctrl.fields.trig_level  = level[`SCOPE_SAMPLE_W-1:0];
    ctrl.fields.trig_edge   = rise[0];
    ramp_step               = step[`SCOPE_SAMPLE_W-1:0];
    prod                    = step * (deci + 1);
    inc                     = prod[`SCOPE_SAMPLE_W-1:0];
    apb_write(CTRL_OFFS, ctrl.raw, err);
    ctrl.fields.run = 1'b1;
    apb_write(CTRL_OFFS, ctrl.raw, err);
    apb_read(CTRL_OFFS, rdata, err);
    check_value("prdata", ctrl.raw, rdata);
    apb_read(STATUS_OFFS, rdata, err);
    check_value("status_done", 32'd0, rdata[STATUS_DONE_BIT]);
    // two buffer fills plus room for the ramp to reach the trigger level
    limit = (2 * BUF_DEPTH + 512) * (deci + 1);
    start = cycle_cnt;
    done  = 1'b0;
    while (!done && (cycle_cnt - start) < limit) begin
      apb_read(STATUS_OFFS, rdata, err);
      done = rdata[STATUS_DONE_BIT];
    end
    // stop at once so the next trigger does not overwrite the frame
    ctrl.fields.run = 1'b0;
    apb_write(CTRL_OFFS, ctrl.raw, err);
    if (!done) begin
      other_errors++;
      $display("STATUS done bit did not set within %0d cycles", limit);
    end else begin
      apb_read(STATUS_OFFS, rdata, err);
      check_value("status_done", 32'd1, rdata[STATUS_DONE_BIT]);
      check_value("status_armed", 32'd1, rdata[STATUS_ARMED_BIT]);
      for (i = 0; i < nwords; i++) begin
        apb_read(`SCOPE_BUF_BASE + 4 * i, rdata, err);
        words[i] = rdata[`SCOPE_SAMPLE_W-1:0];
        check_value("pslverr", 32'd0, err);
        check_value("prdata_upper", 32'd0, rdata[31:`SCOPE_SAMPLE_W]);
      end
      // stored samples are deci_factor+1 ramp steps apart
      for (i = 1; i < nwords; i++) begin
        exp_word = words[i-1] + inc;
        check_value($sformatf("buf_word[%0d]", i), exp_word, words[i]);
      end
      // the trigger sample sits one decimation period before word 0
      trig = words[0] - inc;
      prev = trig - ramp_step;
      if (rise != 0) begin
        check_value("trig_prev_below_level", 32'd1, prev < ctrl.fields.trig_level);
        check_value("trig_at_or_above_level", 32'd1, trig >= ctrl.fields.trig_level);
      end else begin
        check_value("trig_prev_above_level", 32'd1, prev > ctrl.fields.trig_level);
        check_value("trig_at_or_below_level", 32'd1, trig <= ctrl.fields.trig_level);
      end
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    tests;
    int    deci;
    int    level;
    int    rise;
    int    step;
    int    nwords;
    int    total;
    string line;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    tests   = 0;
    repeat (2) @(negedge ad_clk);
    rst_n = 1'b1;
    check_registers();
    fd = $fopen("verification/scope_capture_tests.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the test data file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %d %d %d", deci, level, rise, step, nwords);
          if (n == 5) begin
            tests++;
            run_capture(deci, level, rise, step, nwords);
          end
        end
      end
      $fclose(fd);
    end
    if (tests == 0) begin
      other_errors++;
      $display("no test cases were read from the data file");
    end
    total = value_errors + other_errors + dut.u_asserts.fail_count;
    $display("tests %0d, checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
             tests, check_cnt, value_errors, other_errors, dut.u_asserts.fail_count);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== scope_capture.f ====
+incdir+rtl
rtl/scope_regs_pkg.sv
rtl/scope_capture_pkg.sv
rtl/ad_decimator.sv
rtl/ad9280_sample.sv
rtl/wave_buffer.sv
rtl/scope_apb_regs.sv
rtl/scope_capture.sv
verification/scope_capture_asserts.sv
verification/scope_capture_tb.sv

// ==== verification/scope_capture_tests.txt ====
# columns: deci_factor trig_level edge step words, all decimal
# edge 1 is rising and 0 is falling, step is added to ad_data every clock modulo 256
0 128 1 1 256
0 64 0 -1 256
2 200 1 3 128
4 40 0 -2 128
0 17 1 5 200
6 150 1 1 64
2 90 0 -7 100
0 100 1 8 300
